/* list.f */
rtl/fv_pkg.sv
rtl/fv_req_fifo.sv
rtl/fv_dispatch.sv
rtl/fv_bank_ctrl.sv
rtl/fv_sram_bank.sv
rtl/fv_bus_arbiter.sv
rtl/fv_sram_top.sv
test/tb_clock_gen.sv
test/tb_fv_checker.sv
test/tb_fv_sram.sv

/* Bender.yml */
package:
  name: fv_sram

sources:
  - files:
      - rtl/fv_pkg.sv
      - rtl/fv_req_fifo.sv
      - rtl/fv_dispatch.sv
      - rtl/fv_bank_ctrl.sv
      - rtl/fv_sram_bank.sv
      - rtl/fv_bus_arbiter.sv
      - rtl/fv_sram_top.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/tb_fv_checker.sv
      - test/tb_fv_sram.sv

/* test/tb_fv_sram.sv */
`timescale 1ns/10ps

module tb_fv_sram;

    localparam int MAX_FV      = (1 << fv_pkg::NUM_FV_W) - 1;
    localparam int ALL_WORDS   = fv_pkg::NUM_BANKS * fv_pkg::BANK_DEPTH;
    localparam int DRIVE_DELAY = 10;
    localparam int WAIT_LIMIT  = 2000;

    logic                        clk;
    logic                        rst_n;
    logic                        req_valid;
    logic [fv_pkg::TAG_W-1:0]    req_tag;
    fv_pkg::fv_addr_u            req_addr;
    logic [fv_pkg::NUM_FV_W-1:0] num_fv;
    logic                        mem_wr_en;
    fv_pkg::fv_addr_u            mem_wr_addr;
    logic [fv_pkg::FV_WIDTH-1:0] mem_wr_data;
    logic                        out_ready;
    logic                        wfull;
    logic                        out_valid;
    logic [fv_pkg::TAG_W-1:0]    out_tag;
    logic [fv_pkg::FV_WIDTH-1:0] out_data;
    logic                        out_last;
    int                          pending;
    int                          err_count;

    logic [fv_pkg::FV_WIDTH-1:0] shadow [ALL_WORDS];  // Flat copy of both banks.
    logic [31:0]                 rng;

    tb_clock_gen u_clk (.clk(clk), .rst_n(rst_n));

    fv_sram_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req_tag     (req_tag),
        .req_addr    (req_addr),
        .num_fv      (num_fv),
        .mem_wr_en   (mem_wr_en),
        .mem_wr_addr (mem_wr_addr),
        .mem_wr_data (mem_wr_data),
        .out_ready   (out_ready),
        .wfull       (wfull),
        .out_valid   (out_valid),
        .out_tag     (out_tag),
        .out_data    (out_data),
        .out_last    (out_last)
    );

    tb_fv_checker u_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_tag   (out_tag),
        .out_data  (out_data),
        .out_last  (out_last),
        .wfull     (wfull),
        .pending   (pending),
        .err_count (err_count)
    );

    // ----------------------------------------
    // Random numbers and reference model
    // ----------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic draw(output logic [31:0] value);
        rng   = xorshift32(rng);
        value = rng;
    endtask

    // Word k of the vector at addr; the row wraps inside its bank.
    function automatic logic [fv_pkg::FV_WIDTH-1:0] fv_expect(input fv_pkg::fv_addr_u addr,
                                                               input int k);
        fv_pkg::fv_addr_u a;
        a        = addr;
        a.br.row = addr.br.row + fv_pkg::ROW_W'(k);
        return shadow[a.flat];
    endfunction

    // ----------------------------------------
    // Stimulus tasks
    // ----------------------------------------
    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic abort(input string what);
        $display("Timeout while waiting for %s", what);
        $display("TESTS FAILED");
        $finish;
    endtask

    task automatic load_word(input int flat, input logic [fv_pkg::FV_WIDTH-1:0] data);
        mem_wr_en        = 1'b1;
        mem_wr_addr.flat = fv_pkg::ADDR_W'(flat);
        mem_wr_data      = data;
        shadow[flat]     = data;
        next_cycle();
        mem_wr_en = 1'b0;
    endtask

    task automatic push_request(input fv_pkg::fv_addr_u addr,
                                input logic [fv_pkg::TAG_W-1:0] tag);
        logic [MAX_FV*fv_pkg::FV_WIDTH-1:0] words;
        int                                 n;
        n = 0;
        while (wfull) begin
            if (n >= WAIT_LIMIT) begin
                abort("wfull to drop");
            end
            next_cycle();
            n++;
        end
        words = '0;
        for (int k = 0; k < int'(num_fv); k++) begin
            words[k*fv_pkg::FV_WIDTH +: fv_pkg::FV_WIDTH] = fv_expect(addr, k);
        end
        u_checker.add_vector(int'(addr.br.bank), tag, int'(num_fv), words);
        req_valid = 1'b1;
        req_tag   = tag;
        req_addr  = addr;
        next_cycle();
        req_valid = 1'b0;
    endtask

    task automatic wait_idle(input bit rand_ready);
        logic [31:0] r;
        int          n;
        n = 0;
        while (pending != 0) begin
            if (n >= WAIT_LIMIT) begin
                abort("all queued vectors to arrive");
            end
            if (rand_ready) begin
                draw(r);
                out_ready = (r[1:0] != 2'b00);  // Ready three cycles in four.
            end
            next_cycle();
            n++;
        end
        out_ready = 1'b1;
    endtask

    initial begin
        logic [31:0]      r;
        fv_pkg::fv_addr_u a;
        int               n;
        int               accepted;
        int               bank0;
        int               bank1;
        rng         = 32'd14605;
        req_valid   = 1'b0;
        req_tag     = '0;
        req_addr    = '0;
        num_fv      = 4'd1;
        mem_wr_en   = 1'b0;
        mem_wr_addr = '0;
        mem_wr_data = '0;
        out_ready   = 1'b1;
        bank0       = 0;
        bank1       = 0;

        next_cycle();
        n = 0;
        while (rst_n !== 1'b1) begin
            if (n >= 10) begin
                abort("reset release");
            end
            next_cycle();
            n++;
        end

        u_checker.begin_test("load_single");
        u_checker.check_full("wfull after reset", 1'b0);
        u_checker.check_value("out_valid after reset", 0, int'(out_valid));
        for (int i = 0; i < ALL_WORDS; i++) begin
            draw(r);
            load_word(i, r[15:0]);
        end
        for (int b = 0; b < fv_pkg::NUM_BANKS; b++) begin
            draw(r);
            a.br.bank = fv_pkg::BANK_W'(b);
            a.br.row  = r[7:0];
            push_request(a, r[9:8]);
            wait_idle(1'b0);
        end
        u_checker.end_test();

        u_checker.begin_test("streaming");
        for (int i = 0; i < 10; i++) begin
            draw(r);
            num_fv = fv_pkg::NUM_FV_W'((r[15:0] % MAX_FV) + 1);
            a.flat = r[24:16];
            if (i < 2) begin
                a.br.bank = fv_pkg::BANK_W'(i);  // Both banks cross row 255.
                a.br.row  = 8'd250;
                num_fv    = 4'd12;
            end
            push_request(a, r[27:26]);
            wait_idle(1'b0);
        end
        u_checker.end_test();

        u_checker.begin_test("interleave");
        num_fv = 4'd7;
        for (int i = 0; i < 12; i++) begin
            draw(r);
            a.br.bank = (i < 6) ? fv_pkg::BANK_W'(i % 2) : r[8];
            a.br.row  = r[7:0];
            push_request(a, r[11:10]);
        end
        wait_idle(1'b1);
        u_checker.end_test();

        u_checker.begin_test("backpressure");
        num_fv    = 4'd5;
        out_ready = 1'b0;
        accepted  = 0;
        n         = 0;
        while (!wfull) begin
            if (n >= 20) begin
                abort("wfull to rise");
            end
            draw(r);
            a.flat = r[8:0];
            if (accepted == 0) begin
                bank0 = int'(a.br.bank);
            end else if (accepted == 1) begin
                bank1 = int'(a.br.bank);
            end
            push_request(a, r[13:12]);
            accepted++;
            n++;
        end
        repeat (5) next_cycle();
        u_checker.check_full("wfull under back-pressure", 1'b1);
        // One request per idle bank leaves the FIFO before it fills.
        u_checker.check_value("accepted requests", fv_pkg::FIFO_DEPTH + ((bank0 != bank1) ? 2 : 1),
                              accepted);
        out_ready = 1'b1;
        wait_idle(1'b0);
        u_checker.end_test();

        u_checker.begin_test("load_priority");
        num_fv = 4'd15;
        draw(r);
        a.br.bank = r[8];
        a.br.row  = r[7:0];
        push_request(a, r[17:16]);
        for (int j = 0; j < 8; j++) begin
            draw(r);
            load_word(int'({a.br.bank, a.br.row + 8'(64 + j)}), r[15:0]);
            next_cycle();
        end
        wait_idle(1'b0);
        num_fv   = 4'd8;
        a.br.row = a.br.row + 8'd64;  // Read back the freshly loaded rows.
        push_request(a, r[21:20]);
        wait_idle(1'b0);
        u_checker.end_test();

        u_checker.summary();
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* test/tb_fv_checker.sv */
`timescale 1ns/10ps

module tb_fv_checker (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        out_valid,
    input  logic                        out_ready,
    input  logic [fv_pkg::TAG_W-1:0]    out_tag,
    input  logic [fv_pkg::FV_WIDTH-1:0] out_data,
    input  logic                        out_last,
    input  logic                        wfull,
    output int                          pending,
    output int                          err_count
);

    localparam int MAX_FV = (1 << fv_pkg::NUM_FV_W) - 1;
    localparam int SLOTS  = 32;

    // ----------------------------------------
    // Expected vectors, one ring per bank
    // ----------------------------------------
    logic [fv_pkg::TAG_W-1:0]    exp_tag  [fv_pkg::NUM_BANKS][SLOTS];
    int                          exp_len  [fv_pkg::NUM_BANKS][SLOTS];
    logic [fv_pkg::FV_WIDTH-1:0] exp_word [fv_pkg::NUM_BANKS][SLOTS][MAX_FV];
    int                          head     [fv_pkg::NUM_BANKS];
    int                          tail     [fv_pkg::NUM_BANKS];

    logic [fv_pkg::FV_WIDTH-1:0] rx_word [MAX_FV];  // Vector being received.
    logic [fv_pkg::TAG_W-1:0]    rx_tag;
    int                          rx_len;
    string                       test_name;
    int                          test_vecs;
    int                          test_errs;
    int                          total_vecs;
    int                          num_tests;

    initial begin
        for (int b = 0; b < fv_pkg::NUM_BANKS; b++) begin
            head[b] = 0;
            tail[b] = 0;
        end
        rx_len     = 0;
        pending    = 0;
        err_count  = 0;
        test_name  = "none";
        test_vecs  = 0;
        test_errs  = 0;
        total_vecs = 0;
        num_tests  = 0;
    end

    task automatic note_error();
        err_count = err_count + 1;
        test_errs = test_errs + 1;
    endtask

    task automatic check_value(input string what, input int exp, input int act);
        if (exp != act) begin
            $display("Fail %s: %s expected %0d actual %0d", test_name, what, exp, act);
            note_error();
        end
    endtask

    task automatic check_full(input string what, input bit exp);
        check_value(what, int'(exp), int'(wfull));
    endtask

    task automatic add_vector(input int bank, input logic [fv_pkg::TAG_W-1:0] tag,
                              input int len, input logic [MAX_FV*fv_pkg::FV_WIDTH-1:0] words);
        int slot;
        slot = tail[bank] % SLOTS;
        exp_tag[bank][slot] = tag;
        exp_len[bank][slot] = len;
        for (int k = 0; k < MAX_FV; k++) begin
            exp_word[bank][slot][k] = words[k*fv_pkg::FV_WIDTH +: fv_pkg::FV_WIDTH];
        end
        tail[bank] = tail[bank] + 1;
        pending    = pending + 1;
    endtask

    function automatic bit head_matches(input int bank);
        int slot;
        slot = head[bank] % SLOTS;
        if (exp_tag[bank][slot] != rx_tag || exp_len[bank][slot] != rx_len) begin
            return 1'b0;
        end
        for (int k = 0; k < rx_len; k++) begin
            if (exp_word[bank][slot][k] !== rx_word[k]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic report_diff(input int bank);
        int slot;
        int n;
        slot = head[bank] % SLOTS;
        check_value("vector length", exp_len[bank][slot], rx_len);
        n = (rx_len < exp_len[bank][slot]) ? rx_len : exp_len[bank][slot];
        for (int k = 0; k < n; k++) begin
            if (exp_word[bank][slot][k] !== rx_word[k]) begin
                $display("Fail %s: bank %0d word %0d expected 0x%04h actual 0x%04h",
                         test_name, bank, k, exp_word[bank][slot][k], rx_word[k]);
                note_error();
            end
        end
        head[bank] = head[bank] + 1;
        pending    = pending - 1;
    endtask

    // Matches a complete vector against the head of each bank ring.
    task automatic close_vector();
        int hit;
        int cand;
        hit  = -1;
        cand = -1;
        for (int b = 0; b < fv_pkg::NUM_BANKS; b++) begin
            if (hit < 0 && head[b] != tail[b]) begin
                if (head_matches(b)) begin
                    hit = b;
                end else if (cand < 0 && exp_tag[b][head[b] % SLOTS] == rx_tag) begin
                    cand = b;
                end
            end
        end
        if (hit >= 0) begin
            head[hit] = head[hit] + 1;
            pending   = pending - 1;
            test_vecs = test_vecs + 1;
        end else if (cand >= 0) begin
            report_diff(cand);
        end else begin
            $display("Error in %s: a vector with tag %0d and %0d words matches no request",
                     test_name, rx_tag, rx_len);
            note_error();
        end
        rx_len = 0;
    endtask

    // Sampled mid-cycle, where the bus is stable before the transfer edge.
    always @(negedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (rx_len == 0) begin
                rx_tag = out_tag;
            end else begin
                check_value("tag within vector", int'(rx_tag), int'(out_tag));
            end
            rx_word[rx_len] = out_data;
            rx_len = rx_len + 1;
            if (out_last) begin
                close_vector();
            end else if (rx_len == MAX_FV) begin
                $display("Error in %s: %0d words arrived without out_last", test_name, rx_len);
                note_error();
                rx_len = 0;
            end
        end
    end

    task automatic begin_test(input string name);
        test_name = name;
        test_vecs = 0;
        test_errs = 0;
    endtask

    task automatic end_test();
        if (rx_len != 0) begin
            $display("Error in %s: a vector of %0d words never got out_last", test_name, rx_len);
            note_error();
            rx_len = 0;
        end
        $display("Test %s: %0d vectors, %0d errors", test_name, test_vecs, test_errs);
        num_tests  = num_tests + 1;
        total_vecs = total_vecs + test_vecs;
    endtask

    task automatic summary();
        $display("Done: %0d tests, %0d vectors, %0d errors", num_tests, total_vecs, err_count);
    endtask

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 50;  // 100 ns clock.

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #10;
        rst_n = 1'b1;  // Released after two rising edges.
    end

endmodule

/* rtl/fv_sram_top.sv */
`timescale 1ns/10ps

module fv_sram_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid,
    input  logic [fv_pkg::TAG_W-1:0]    req_tag,
    input  fv_pkg::fv_addr_u            req_addr,
    input  logic [fv_pkg::NUM_FV_W-1:0] num_fv,
    input  logic                        mem_wr_en,
    input  fv_pkg::fv_addr_u            mem_wr_addr,
    input  logic [fv_pkg::FV_WIDTH-1:0] mem_wr_data,
    input  logic                        out_ready,
    output logic                        wfull,
    output logic                        out_valid,
    output logic [fv_pkg::TAG_W-1:0]    out_tag,
    output logic [fv_pkg::FV_WIDTH-1:0] out_data,
    output logic                        out_last
);

    logic                                               fifo_empty;
    logic                                               fifo_pop;
    logic [fv_pkg::TAG_W-1:0]                           head_tag;
    fv_pkg::fv_addr_u                                   head_addr;
    logic [fv_pkg::NUM_BANKS-1:0]                       busy;
    logic [fv_pkg::NUM_BANKS-1:0]                       start;
    logic [fv_pkg::TAG_W-1:0]                           start_tag;
    logic [fv_pkg::ROW_W-1:0]                           start_row;
    logic [fv_pkg::NUM_BANKS-1:0]                       sram_cen;
    logic [fv_pkg::NUM_BANKS-1:0]                       sram_wen;
    logic [fv_pkg::NUM_BANKS-1:0][fv_pkg::ROW_W-1:0]    sram_a;
    logic [fv_pkg::NUM_BANKS-1:0][fv_pkg::FV_WIDTH-1:0] sram_d;
    logic [fv_pkg::NUM_BANKS-1:0][fv_pkg::FV_WIDTH-1:0] sram_q;
    logic [fv_pkg::NUM_BANKS-1:0]                       word_valid;
    logic [fv_pkg::NUM_BANKS-1:0][fv_pkg::FV_WIDTH-1:0] word_data;
    logic [fv_pkg::NUM_BANKS-1:0][fv_pkg::TAG_W-1:0]    word_tag;
    logic [fv_pkg::NUM_BANKS-1:0]                       word_last;
    logic [fv_pkg::NUM_BANKS-1:0]                       grant;

    fv_req_fifo u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req_tag    (req_tag),
        .req_addr   (req_addr),
        .fifo_pop   (fifo_pop),
        .wfull      (wfull),
        .fifo_empty (fifo_empty),
        .head_tag   (head_tag),
        .head_addr  (head_addr)
    );

    fv_dispatch u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .fifo_empty (fifo_empty),
        .head_tag   (head_tag),
        .head_addr  (head_addr),
        .busy       (busy),
        .fifo_pop   (fifo_pop),
        .start      (start),
        .start_tag  (start_tag),
        .start_row  (start_row)
    );

    // ----------------------------------------
    // One controller and one SRAM per bank
    // ----------------------------------------
    for (genvar i = 0; i < fv_pkg::NUM_BANKS; i++) begin : g_bank
        fv_bank_ctrl #(
            .BANK_ID (i)
        ) u_ctrl (
            .clk         (clk),
            .rst_n       (rst_n),
            .num_fv      (num_fv),
            .start       (start[i]),
            .start_tag   (start_tag),
            .start_row   (start_row),
            .mem_wr_en   (mem_wr_en),
            .mem_wr_addr (mem_wr_addr),
            .mem_wr_data (mem_wr_data),
            .grant       (grant[i]),
            .out_ready   (out_ready),
            .sram_q      (sram_q[i]),
            .busy        (busy[i]),
            .sram_cen    (sram_cen[i]),
            .sram_wen    (sram_wen[i]),
            .sram_a      (sram_a[i]),
            .sram_d      (sram_d[i]),
            .word_valid  (word_valid[i]),
            .word_data   (word_data[i]),
            .word_tag    (word_tag[i]),
            .word_last   (word_last[i])
        );

        fv_sram_bank u_sram (
            .clk (clk),
            .cen (sram_cen[i]),
            .wen (sram_wen[i]),
            .a   (sram_a[i]),
            .d   (sram_d[i]),
            .q   (sram_q[i])
        );
    end

    fv_bus_arbiter u_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .word_valid (word_valid),
        .word_data  (word_data),
        .word_tag   (word_tag),
        .word_last  (word_last),
        .out_ready  (out_ready),
        .grant      (grant),
        .out_valid  (out_valid),
        .out_tag    (out_tag),
        .out_data   (out_data),
        .out_last   (out_last)
    );

endmodule

/* rtl/fv_bus_arbiter.sv */
`timescale 1ns/10ps

module fv_bus_arbiter (
    input  logic                                               clk,
    input  logic                                               rst_n,
    input  logic [fv_pkg::NUM_BANKS-1:0]                       word_valid,
    input  logic [fv_pkg::NUM_BANKS-1:0][fv_pkg::FV_WIDTH-1:0] word_data,
    input  logic [fv_pkg::NUM_BANKS-1:0][fv_pkg::TAG_W-1:0]    word_tag,
    input  logic [fv_pkg::NUM_BANKS-1:0]                       word_last,
    input  logic                                               out_ready,
    output logic [fv_pkg::NUM_BANKS-1:0]                       grant,
    output logic                                               out_valid,
    output logic [fv_pkg::TAG_W-1:0]                           out_tag,
    output logic [fv_pkg::FV_WIDTH-1:0]                        out_data,
    output logic                                               out_last
);

    logic [fv_pkg::BANK_W-1:0] ptr;  // Last served bank, or the owner while locked.
    logic                      locked;
    logic [fv_pkg::BANK_W-1:0] rr_pick;
    logic                      rr_found;
    logic [fv_pkg::BANK_W-1:0] sel;
    logic                      owned;

    // Search starts one past the last served bank.
    always_comb begin
        rr_pick  = ptr;
        rr_found = 1'b0;
        for (int i = 1; i <= fv_pkg::NUM_BANKS; i++) begin
            if (!rr_found && word_valid[(int'(ptr) + i) % fv_pkg::NUM_BANKS]) begin
                rr_pick  = fv_pkg::BANK_W'((int'(ptr) + i) % fv_pkg::NUM_BANKS);
                rr_found = 1'b1;
            end
        end
    end

    assign sel   = locked ? ptr : rr_pick;
    assign owned = locked || rr_found;

    always_comb begin
        grant = '0;
        if (owned) begin
            grant[sel] = 1'b1;
        end
    end

    assign out_valid = owned && word_valid[sel];
    assign out_tag   = word_tag[sel];
    assign out_data  = word_data[sel];
    assign out_last  = word_last[sel];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr    <= '0;
            locked <= 1'b0;
        end else if (out_valid && out_ready) begin
            ptr    <= sel;
            locked <= !out_last;  // Hold the bus until the burst ends.
        end
    end

endmodule

/* rtl/fv_sram_bank.sv */
`timescale 1ns/10ps

module fv_sram_bank (
    input  logic                        clk,
    input  logic                        cen,
    input  logic                        wen,
    input  logic [fv_pkg::ROW_W-1:0]    a,
    input  logic [fv_pkg::FV_WIDTH-1:0] d,
    output logic [fv_pkg::FV_WIDTH-1:0] q
);

    logic [fv_pkg::FV_WIDTH-1:0] mem [fv_pkg::BANK_DEPTH];

    // The output register changes only on a read, so a word waits there under back-pressure.
    always_ff @(posedge clk) begin
        if (!cen) begin
            if (!wen) begin
                mem[a] <= d;
            end else begin
                q <= mem[a];
            end
        end
    end

endmodule

/* rtl/fv_bank_ctrl.sv */
`timescale 1ns/10ps

module fv_bank_ctrl #(
    parameter int BANK_ID = 0
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [fv_pkg::NUM_FV_W-1:0] num_fv,
    input  logic                        start,
    input  logic [fv_pkg::TAG_W-1:0]    start_tag,
    input  logic [fv_pkg::ROW_W-1:0]    start_row,
    input  logic                        mem_wr_en,
    input  fv_pkg::fv_addr_u            mem_wr_addr,
    input  logic [fv_pkg::FV_WIDTH-1:0] mem_wr_data,
    input  logic                        grant,
    input  logic                        out_ready,
    input  logic [fv_pkg::FV_WIDTH-1:0] sram_q,
    output logic                        busy,
    output logic                        sram_cen,
    output logic                        sram_wen,
    output logic [fv_pkg::ROW_W-1:0]    sram_a,
    output logic [fv_pkg::FV_WIDTH-1:0] sram_d,
    output logic                        word_valid,
    output logic [fv_pkg::FV_WIDTH-1:0] word_data,
    output logic [fv_pkg::TAG_W-1:0]    word_tag,
    output logic                        word_last
);

    logic [fv_pkg::NUM_FV_W-1:0] rd_left;  // Reads still to issue.
    logic [fv_pkg::ROW_W-1:0]    row_ptr;
    logic                        rd_pend;  // The SRAM output holds an unconsumed word.
    logic                        pend_last;
    logic                        load_hit;
    logic                        xfer;
    logic                        hold_load;
    logic                        rd_issue;

    assign load_hit  = mem_wr_en && (mem_wr_addr.br.bank == fv_pkg::BANK_W'(BANK_ID));
    assign xfer      = word_valid && grant && out_ready;
    assign hold_load = rd_pend && (!word_valid || xfer);
    assign rd_issue  = (rd_left != '0) && !load_hit && (!rd_pend || hold_load);

    // ----------------------------------------
    // SRAM port, load writes first
    // ----------------------------------------
    assign sram_cen = !(load_hit || rd_issue);
    assign sram_wen = !load_hit;
    assign sram_a   = load_hit ? mem_wr_addr.br.row : row_ptr;
    assign sram_d   = mem_wr_data;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            rd_left    <= '0;
            rd_pend    <= 1'b0;
            word_valid <= 1'b0;
        end else begin
            if (start) begin
                busy    <= 1'b1;
                rd_left <= num_fv;
            end else begin
                if (xfer && word_last) begin
                    busy <= 1'b0;  // Vector fully delivered.
                end
                if (rd_issue) begin
                    rd_left <= rd_left - 1'b1;
                end
            end
            if (rd_issue) begin
                rd_pend <= 1'b1;
            end else if (hold_load) begin
                rd_pend <= 1'b0;
            end
            if (hold_load) begin
                word_valid <= 1'b1;
            end else if (xfer) begin
                word_valid <= 1'b0;
            end
        end
    end

    // ----------------------------------------
    // Vector context and holding register
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (start) begin
            word_tag <= start_tag;
            row_ptr  <= start_row;
        end else if (rd_issue) begin
            row_ptr <= row_ptr + 1'b1;  // Wraps within the bank.
        end
        if (rd_issue) begin
            pend_last <= (rd_left == fv_pkg::NUM_FV_W'(1));
        end
        if (hold_load) begin
            word_data <= sram_q;
            word_last <= pend_last;
        end
    end

endmodule

/* rtl/fv_dispatch.sv */
`timescale 1ns/10ps

module fv_dispatch (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         fifo_empty,
    input  logic [fv_pkg::TAG_W-1:0]     head_tag,
    input  fv_pkg::fv_addr_u             head_addr,
    input  logic [fv_pkg::NUM_BANKS-1:0] busy,
    output logic                         fifo_pop,
    output logic [fv_pkg::NUM_BANKS-1:0] start,
    output logic [fv_pkg::TAG_W-1:0]     start_tag,
    output logic [fv_pkg::ROW_W-1:0]     start_row
);

    logic [fv_pkg::BANK_W-1:0] head_bank;
    logic                      go;

    assign head_bank = head_addr.br.bank;

    // While a pop is in flight the head is stale and the started bank has not yet raised busy.
    assign go = !fifo_empty && !fifo_pop && !busy[head_bank];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fifo_pop <= 1'b0;
            start    <= '0;
        end else begin
            fifo_pop <= go;  // Pop and start leave together.
            start    <= '0;
            if (go) begin
                start[head_bank] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (go) begin
            start_tag <= head_tag;
            start_row <= head_addr.br.row;
        end
    end

endmodule

/* rtl/fv_req_fifo.sv */
`timescale 1ns/10ps

module fv_req_fifo (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid,
    input  logic [fv_pkg::TAG_W-1:0] req_tag,
    input  fv_pkg::fv_addr_u         req_addr,
    input  logic                     fifo_pop,
    output logic                     wfull,
    output logic                     fifo_empty,
    output logic [fv_pkg::TAG_W-1:0] head_tag,
    output fv_pkg::fv_addr_u         head_addr
);

    localparam int PTR_W = $clog2(fv_pkg::FIFO_DEPTH);
    localparam int CNT_W = $clog2(fv_pkg::FIFO_DEPTH + 1);

    logic [fv_pkg::TAG_W-1:0] tag_mem  [fv_pkg::FIFO_DEPTH];
    fv_pkg::fv_addr_u         addr_mem [fv_pkg::FIFO_DEPTH];
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic [CNT_W-1:0]         count;
    logic                     push;
    logic                     pop;

    assign push = req_valid && !wfull;  // A strobe while full is lost.
    assign pop  = fifo_pop && !fifo_empty;

    assign wfull      = (count == CNT_W'(fv_pkg::FIFO_DEPTH));
    assign fifo_empty = (count == '0);
    assign head_tag   = tag_mem[rd_ptr];
    assign head_addr  = addr_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (push) begin
            tag_mem[wr_ptr]  <= req_tag;
            addr_mem[wr_ptr] <= req_addr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two, so pointers wrap.
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

/* rtl/fv_pkg.sv */
package fv_pkg;

    // ----------------------------------------
    // Feature-vector memory sizes
    // ----------------------------------------
    localparam int FV_WIDTH   = 16;  // One feature-vector word.
    localparam int NUM_BANKS  = 2;
    localparam int BANK_DEPTH = 256;  // Words per bank.
    localparam int ROW_W      = 8;
    localparam int BANK_W     = 1;
    localparam int ADDR_W     = BANK_W + ROW_W;

    // ----------------------------------------
    // Request fields
    // ----------------------------------------
    localparam int TAG_W      = 2;  // Four edge PEs.
    localparam int NUM_FV_W   = 4;  // Vectors of 1 to 15 words.
    localparam int FIFO_DEPTH = 4;

    // A feature-vector address is either a flat word address or a bank/row pair.
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        struct packed {
            logic [BANK_W-1:0] bank;  // Top bit selects the bank.
            logic [ROW_W-1:0]  row;
        } br;
    } fv_addr_u;

endpackage
